/* sim.f */
verilog/cfg_pkg.sv
verilog/cfg_unlock.sv
verilog/cfg_regs.sv
verilog/cmd_executor.sv
verilog/cfg_top.sv
testbench/cfg_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the mailbox testbench with Verilator and runs it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot change to the project root"
    exit 1
fi

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module cfg_tb \
    -Mdir "$BUILD_DIR" -o cfg_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/cfg_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

grep -q "^NO ERRORS$" "$LOG"
if [ $? -ne 0 ]; then
    echo "Simulation failed, see $LOG"
    exit 1
fi

echo "Simulation passed"
exit 0

/* testbench/cfg_tb.sv */
`timescale 1ns/1ps

module cfg_tb
    import cfg_pkg::*;
();

    localparam int CMD_LATENCY = 4;
    localparam int POLL_LIMIT  = 8 * CMD_LATENCY + 32;
    localparam logic [ADDR_W-1:0] STATUS_ADDR = 17'h1_0000; // STATUS is slot 0 at the window base

    logic              clk = 1'b0;
    logic              rst_n;
    logic              soft_reset;
    logic              write;
    logic [ADDR_W-1:0] address;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    logic              irq;

    int          errors    = 0;
    int          timeouts  = 0;
    logic [31:0] rng_state = 32'd32;

    cfg_top #(
        .CMD_LATENCY (CMD_LATENCY)
    ) u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .soft_reset (soft_reset),
        .write      (write),
        .address    (address),
        .wdata      (wdata),
        .rdata      (rdata),
        .irq        (irq)
    );

    always #10 clk = ~clk;

    irq_matches_status: assert property (@(posedge clk) disable iff (!rst_n)
        (address == STATUS_ADDR) |-> (rdata[STAT_IRQ_BIT] == irq)) else begin
        errors++;
        $display("ERROR at time %0t: STATUS irq bit differs from irq output", $time);
    end

    outside_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (!address[16]) |-> (rdata == 16'h0000)) else begin
        errors++;
        $display("ERROR at time %0t: read outside the window is %h", $time, rdata);
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw_random(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value     = rng_state;
    endtask

    function automatic logic [ADDR_W-1:0] slot_addr(input reg_index_e idx);
        return {1'b1, 11'd0, idx, 1'b0};
    endfunction

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("ERROR at time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(posedge clk);
        write   <= 1'b1;
        address <= addr;
        wdata   <= data;
        @(posedge clk);
        write   <= 1'b0; // Previous edge was the write edge
    endtask

    task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        @(posedge clk);
        address <= addr;
        @(negedge clk);
        data = rdata;
    endtask

    task automatic write_word(input reg_index_e hi, input logic [31:0] value);
        write_reg(slot_addr(hi), value[31:16]);
        write_reg(slot_addr(hi) + 17'd2, value[15:0]);
    endtask

    task automatic read_word(input reg_index_e hi, output logic [31:0] value);
        logic [DATA_W-1:0] upper;
        logic [DATA_W-1:0] lower;
        read_reg(slot_addr(hi), upper);
        read_reg(slot_addr(hi) + 17'd2, lower);
        value = {upper, lower};
    endtask

    task automatic unlock_mailbox();
        for (int i = 0; i < 4; i++) begin
            write_reg(slot_addr(i[0] ? REG_KEY_L : REG_KEY_H), UNLOCK_KEY[i[1:0]]);
        end
    endtask

    task automatic pulse_soft_reset();
        @(posedge clk);
        soft_reset <= 1'b1;
        @(posedge clk);
        soft_reset <= 1'b0;
    endtask

    // Expects the address on STATUS and counts edges until pending reads zero
    task automatic wait_idle(output logic [DATA_W-1:0] first_status, output int cycles);
        cycles = 0;
        @(negedge clk);
        first_status = rdata;
        while (rdata[STAT_PENDING_BIT] && cycles < POLL_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (rdata[STAT_PENDING_BIT]) begin
            timeouts++;
            $display("Timeout: command still pending after %0d cycles", cycles);
        end
    endtask

    task automatic run_command(input logic [7:0] code, output logic [DATA_W-1:0] first_status,
                               output int cycles);
        write_reg(slot_addr(REG_COMMAND), {8'h00, code});
        address <= STATUS_ADDR;
        wait_idle(first_status, cycles);
    endtask

    initial begin
        logic [DATA_W-1:0] d;
        logic [DATA_W-1:0] st;
        logic [31:0]       a0;
        logic [31:0]       a1;
        logic [31:0]       r0;
        logic [31:0]       r1;
        logic [31:0]       exp0;
        logic [31:0]       exp1;
        int                cycles;

        rst_n      = 1'b0;
        soft_reset = 1'b0;
        write      = 1'b0;
        address    = '0;
        wdata      = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // Locked mailbox ignores commands and arguments
        write_word(REG_DATA_0_H, 32'h1234_5678);
        run_command(CMD_ADD, st, cycles);
        check_equal("STATUS while locked", 32'(st), 32'h0);
        read_word(REG_DATA_0_H, r0);
        check_equal("DATA_0 after reset", r0, 32'h0);
        read_word(REG_DATA_1_H, r1);
        check_equal("DATA_1 after reset", r1, 32'h0);
        check_equal("irq while locked", 32'(irq), 32'h0);
        read_word(REG_VERSION_H, r0);
        check_equal("VERSION", r0, CFG_VERSION);
        read_reg(17'h0_1002, d);
        check_equal("read below window", 32'(d), 32'h0);
        read_reg(17'h1_0020, d); // Bit 5 set is outside the 32-byte window
        check_equal("read past window", 32'(d), 32'h0);

        // Wrong word in the middle of the key
        write_reg(slot_addr(REG_KEY_H), UNLOCK_KEY[0]);
        write_reg(slot_addr(REG_KEY_H), UNLOCK_KEY[1]);
        write_reg(slot_addr(REG_KEY_H), 16'h1234);
        write_reg(slot_addr(REG_KEY_H), UNLOCK_KEY[3]);
        run_command(CMD_ADD, st, cycles);
        check_equal("pending after bad key", 32'(st[STAT_PENDING_BIT]), 32'h0);

        // Unlock and add
        unlock_mailbox();
        draw_random(a0);
        draw_random(a1);
        write_word(REG_DATA_0_H, a0);
        write_word(REG_DATA_1_H, a1);
        run_command(CMD_ADD, st, cycles);
        check_equal("pending after unlock", 32'(st[STAT_PENDING_BIT]), 32'h1);
        check_equal("ADD pending cycles", cycles, CMD_LATENCY + 1);
        exp0 = a0 + a1;
        exp1 = 32'h0;
        read_word(REG_DATA_0_H, r0);
        check_equal("ADD result 0", r0, exp0);
        read_word(REG_DATA_1_H, r1);
        check_equal("ADD result 1", r1, exp1);

        // Swap with a second command posted while pending
        draw_random(a0);
        draw_random(a1);
        write_word(REG_DATA_0_H, a0);
        write_word(REG_DATA_1_H, a1);
        write_reg(slot_addr(REG_COMMAND), {8'h00, CMD_SWAP});
        write_reg(slot_addr(REG_COMMAND), {8'h00, CMD_ADD});
        address <= STATUS_ADDR;
        wait_idle(st, cycles);
        check_equal("pending during SWAP", 32'(st[STAT_PENDING_BIT]), 32'h1);
        check_equal("SWAP remaining cycles", cycles, CMD_LATENCY - 1);
        exp0 = a1;
        exp1 = a0;
        read_reg(slot_addr(REG_COMMAND), d);
        check_equal("COMMAND after ignored write", 32'(d), 32'(CMD_SWAP));
        read_word(REG_DATA_0_H, r0);
        check_equal("SWAP result 0", r0, exp0);
        read_word(REG_DATA_1_H, r1);
        check_equal("SWAP result 1", r1, exp1);
        repeat (CMD_LATENCY + 2) @(posedge clk);
        read_reg(STATUS_ADDR, d);
        check_equal("STATUS after ignored command", 32'(d), 32'h0);

        // Unknown code
        run_command(8'h7E, st, cycles);
        check_equal("unknown pending cycles", cycles, CMD_LATENCY + 1);
        read_reg(STATUS_ADDR, d);
        check_equal("error bit after unknown", 32'(d[STAT_ERROR_BIT]), 32'h1);
        read_word(REG_DATA_0_H, r0);
        check_equal("result 0 after unknown", r0, exp0);
        draw_random(a0);
        draw_random(a1);
        write_word(REG_DATA_0_H, a0);
        write_word(REG_DATA_1_H, a1);
        run_command(CMD_ADD, st, cycles);
        check_equal("error bit on new command", 32'(st[STAT_ERROR_BIT]), 32'h0);
        exp0 = a0 + a1;
        exp1 = 32'h0;
        read_word(REG_DATA_0_H, r0);
        check_equal("ADD result 0 after unknown", r0, exp0);

        // Interrupt request and acknowledge
        run_command(CMD_IRQ, st, cycles);
        check_equal("irq after IRQ command", 32'(irq), 32'h1);
        repeat (5) @(posedge clk);
        read_reg(STATUS_ADDR, d);
        check_equal("STATUS irq bit held", 32'(d[STAT_IRQ_BIT]), 32'h1);
        read_word(REG_DATA_0_H, r0);
        check_equal("result 0 after IRQ", r0, exp0);
        write_reg(slot_addr(REG_VERSION_L), 16'h0000);
        read_reg(STATUS_ADDR, d);
        check_equal("STATUS irq bit after ack", 32'(d[STAT_IRQ_BIT]), 32'h0);
        check_equal("irq after ack", 32'(irq), 32'h0);

        // Relock with two lock words
        write_reg(slot_addr(REG_KEY_H), LOCK_WORD);
        write_reg(slot_addr(REG_KEY_L), LOCK_WORD);
        run_command(CMD_SWAP, st, cycles);
        check_equal("pending after relock", 32'(st[STAT_PENDING_BIT]), 32'h0);
        read_reg(slot_addr(REG_COMMAND), d);
        check_equal("COMMAND after relock", 32'(d), 32'(CMD_IRQ));

        // Soft reset aborts a command in flight
        unlock_mailbox();
        run_command(CMD_SWAP, st, cycles);
        exp0 = a1;
        exp1 = a0;
        run_command(CMD_IRQ, st, cycles);
        check_equal("irq before soft reset", 32'(irq), 32'h1);
        write_reg(slot_addr(REG_COMMAND), 16'h007E);
        pulse_soft_reset();
        read_reg(STATUS_ADDR, d);
        check_equal("STATUS after soft reset", 32'(d), 32'h0);
        check_equal("irq after soft reset", 32'(irq), 32'h0);
        repeat (CMD_LATENCY + 2) @(posedge clk);
        read_reg(STATUS_ADDR, d);
        check_equal("STATUS after aborted command", 32'(d), 32'h0);
        read_word(REG_DATA_0_H, r0);
        check_equal("result 0 kept over soft reset", r0, exp0);
        read_word(REG_DATA_1_H, r1);
        check_equal("result 1 kept over soft reset", r1, exp1);
        run_command(CMD_ADD, st, cycles);
        check_equal("pending after soft reset", 32'(st[STAT_PENDING_BIT]), 32'h0);

        $display("Finished with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* verilog/cfg_top.sv */
`timescale 1ns/1ps

module cfg_top
    import cfg_pkg::*;
#(
    parameter int CMD_LATENCY = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              soft_reset, // Console reset or NMI
    input  logic              write,
    input  logic [ADDR_W-1:0] address,
    input  logic [DATA_W-1:0] wdata,
    output logic [DATA_W-1:0] rdata,
    output logic              irq
);

    logic              cmd_pending;
    logic [7:0]        cmd;
    logic [WORD_W-1:0] arg0;
    logic [WORD_W-1:0] arg1;
    logic              cmd_done;
    logic              cmd_error;
    logic              cmd_irq;
    logic [WORD_W-1:0] res0;
    logic [WORD_W-1:0] res1;

    cfg_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .soft_reset  (soft_reset),
        .write       (write),
        .address     (address),
        .wdata       (wdata),
        .rdata       (rdata),
        .irq         (irq),
        .cmd_pending (cmd_pending),
        .cmd         (cmd),
        .arg0        (arg0),
        .arg1        (arg1),
        .cmd_done    (cmd_done),
        .cmd_error   (cmd_error),
        .cmd_irq     (cmd_irq),
        .res0        (res0),
        .res1        (res1)
    );

    cmd_executor #(
        .CMD_LATENCY (CMD_LATENCY)
    ) u_executor (
        .clk         (clk),
        .rst_n       (rst_n),
        .soft_reset  (soft_reset),
        .cmd_pending (cmd_pending),
        .cmd         (cmd),
        .arg0        (arg0),
        .arg1        (arg1),
        .cmd_done    (cmd_done),
        .cmd_error   (cmd_error),
        .cmd_irq     (cmd_irq),
        .res0        (res0),
        .res1        (res1)
    );

endmodule

/* verilog/cmd_executor.sv */
`timescale 1ns/1ps

module cmd_executor
    import cfg_pkg::*;
#(
    parameter int CMD_LATENCY = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              soft_reset,

    input  logic              cmd_pending,
    input  logic [7:0]        cmd,
    input  logic [WORD_W-1:0] arg0,
    input  logic [WORD_W-1:0] arg1,

    output logic              cmd_done,
    output logic              cmd_error,
    output logic              cmd_irq,
    output logic [WORD_W-1:0] res0,
    output logic [WORD_W-1:0] res1
);

    // Start edge is one after the command write, so the countdown covers
    // the remaining CMD_LATENCY-1 edges up to the done edge
    localparam int CNT_W = (CMD_LATENCY > 2) ? $clog2(CMD_LATENCY) : 1;
    localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(CMD_LATENCY - 2);

    logic              busy;
    logic [CNT_W-1:0]  cnt;
    logic [7:0]        cmd_q;
    logic [WORD_W-1:0] arg0_q;
    logic [WORD_W-1:0] arg1_q;
    logic              start;
    logic              finish;
    logic              known_cmd;

    // Done is still high on the edge that clears pending, so hold off a restart
    assign start     = !busy && !cmd_done && cmd_pending;
    assign finish    = busy && (cnt == '0);
    assign known_cmd = (cmd_q == CMD_ADD) || (cmd_q == CMD_SWAP) || (cmd_q == CMD_IRQ);

    always_ff @(posedge clk) begin
        if (!rst_n || soft_reset) begin
            busy      <= 1'b0;
            cnt       <= '0;
            cmd_done  <= 1'b0;
            cmd_error <= 1'b0;
            cmd_irq   <= 1'b0;
        end else begin
            cmd_done  <= 1'b0;
            cmd_error <= 1'b0;
            cmd_irq   <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= CNT_LOAD;
            end else if (finish) begin
                busy      <= 1'b0;
                cmd_done  <= 1'b1;
                cmd_error <= !known_cmd;
                cmd_irq   <= (cmd_q == CMD_IRQ);
            end else if (busy) begin
                cnt <= cnt - CNT_W'(1);
            end
        end
    end

    // Command and argument snapshot
    always_ff @(posedge clk) begin
        if (start) begin
            cmd_q  <= cmd;
            arg0_q <= arg0;
            arg1_q <= arg1;
        end
    end

    // Results survive a soft reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res0 <= '0;
            res1 <= '0;
        end else if (finish && !soft_reset) begin
            case (cmd_q)
                CMD_ADD: begin
                    res0 <= arg0_q + arg1_q; // Wraps modulo 2^32
                    res1 <= '0;
                end
                CMD_SWAP: begin
                    res0 <= arg1_q;
                    res1 <= arg0_q;
                end
                default: ; // IRQ and unknown codes keep the results
            endcase
        end
    end

endmodule

/* verilog/cfg_regs.sv */
`timescale 1ns/1ps

module cfg_regs
    import cfg_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              soft_reset,

    input  logic              write,
    input  logic [ADDR_W-1:0] address,
    input  logic [DATA_W-1:0] wdata,
    output logic [DATA_W-1:0] rdata,
    output logic              irq,

    output logic              cmd_pending,
    output logic [7:0]        cmd,
    output logic [WORD_W-1:0] arg0,
    output logic [WORD_W-1:0] arg1,
    input  logic              cmd_done,
    input  logic              cmd_error,
    input  logic              cmd_irq,
    input  logic [WORD_W-1:0] res0,
    input  logic [WORD_W-1:0] res1
);

    logic              win_hit;
    reg_index_e        reg_sel;
    logic              wr_hit;
    logic              key_write;
    logic              unlocked;
    logic              error_flag;
    logic [DATA_W-1:0] status_word;

    // Window is 32 bytes at address bit 16
    assign win_hit   = address[16] && (address[15:5] == 11'd0);
    assign reg_sel   = reg_index_e'(address[4:1]);
    assign wr_hit    = write && win_hit;
    assign key_write = wr_hit && ((reg_sel == REG_KEY_H) || (reg_sel == REG_KEY_L));

    cfg_unlock u_unlock (
        .clk        (clk),
        .rst_n      (rst_n),
        .soft_reset (soft_reset),
        .key_write  (key_write),
        .wdata      (wdata),
        .unlocked   (unlocked)
    );

    always_comb begin
        status_word                   = '0;
        status_word[STAT_PENDING_BIT] = cmd_pending;
        status_word[STAT_ERROR_BIT]   = error_flag;
        status_word[STAT_IRQ_BIT]     = irq;
    end

    always_comb begin
        rdata = '0;
        if (win_hit) begin
            case (reg_sel)
                REG_STATUS:    rdata = status_word;
                REG_COMMAND:   rdata = {8'd0, cmd};
                REG_DATA_0_H:  rdata = res0[31:16];
                REG_DATA_0_L:  rdata = res0[15:0];
                REG_DATA_1_H:  rdata = res1[31:16];
                REG_DATA_1_L:  rdata = res1[15:0];
                REG_VERSION_H: rdata = CFG_VERSION[31:16];
                REG_VERSION_L: rdata = CFG_VERSION[15:0];
                default:       rdata = '0; // Key slots and unused holes
            endcase
        end
    end

    // Command posting and status
    always_ff @(posedge clk) begin
        if (!rst_n || soft_reset) begin
            cmd_pending <= 1'b0;
            cmd         <= 8'h00;
            error_flag  <= 1'b0;
            irq         <= 1'b0;
        end else begin
            if (cmd_done) begin
                cmd_pending <= 1'b0;
                error_flag  <= cmd_error;
                if (cmd_irq) begin
                    irq <= 1'b1;
                end
            end

            if (wr_hit && unlocked) begin
                if (reg_sel == REG_COMMAND && !cmd_pending) begin
                    cmd_pending <= 1'b1;
                    cmd         <= wdata[7:0];
                    error_flag  <= 1'b0;
                end
                if (reg_sel == REG_VERSION_L) begin
                    irq <= 1'b0; // Host acknowledge
                end
            end
        end
    end

    // Argument halves, executor has its own copy once started
    always_ff @(posedge clk) begin
        if (wr_hit && unlocked) begin
            case (reg_sel)
                REG_DATA_0_H: arg0[31:16] <= wdata;
                REG_DATA_0_L: arg0[15:0]  <= wdata;
                REG_DATA_1_H: arg1[31:16] <= wdata;
                REG_DATA_1_L: arg1[15:0]  <= wdata;
                default: ;
            endcase
        end
    end

endmodule

/* verilog/cfg_unlock.sv */
`timescale 1ns/1ps

module cfg_unlock
    import cfg_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              soft_reset,
    input  logic              key_write,
    input  logic [DATA_W-1:0] wdata,
    output logic              unlocked
);

    logic [1:0] seq_cnt;    // Position in UNLOCK_KEY
    logic       unlock_flag;
    logic       lock_cnt;   // Consecutive LOCK_WORD writes

    // Unlock sequence, only active while locked
    always_ff @(posedge clk) begin
        if (!rst_n || soft_reset) begin
            seq_cnt     <= 2'd0;
            unlock_flag <= 1'b0;
        end else begin
            unlock_flag <= 1'b0;
            if (!unlocked && key_write) begin
                if (wdata == UNLOCK_KEY[seq_cnt]) begin
                    seq_cnt <= seq_cnt + 2'd1; // Wraps to zero after the last word
                    if (seq_cnt == 2'd3) begin
                        unlock_flag <= 1'b1;
                    end
                end else begin
                    seq_cnt <= 2'd0;
                end
            end
        end
    end

    // Unlocked state and relock detection
    always_ff @(posedge clk) begin
        if (!rst_n || soft_reset) begin
            unlocked <= 1'b0;
            lock_cnt <= 1'b0;
        end else if (unlocked) begin
            if (key_write) begin
                if (wdata == LOCK_WORD) begin
                    lock_cnt <= ~lock_cnt;
                    if (lock_cnt) begin
                        unlocked <= 1'b0; // Second LOCK_WORD in a row
                    end
                end else begin
                    lock_cnt <= 1'b0;
                end
            end
        end else begin
            lock_cnt <= 1'b0;
            if (unlock_flag) begin
                unlocked <= 1'b1;
            end
        end
    end

endmodule

/* verilog/cfg_pkg.sv */
package cfg_pkg;

    // Bus and payload widths
    localparam int ADDR_W = 17;
    localparam int DATA_W = 16;
    localparam int WORD_W = 32;

    // Register slots, indexed by address bits 4 to 1
    typedef enum logic [3:0] {
        REG_STATUS,
        REG_COMMAND,
        REG_DATA_0_H,
        REG_DATA_0_L,
        REG_DATA_1_H,
        REG_DATA_1_L,
        REG_VERSION_H,
        REG_VERSION_L,
        REG_KEY_H,
        REG_KEY_L
    } reg_index_e;

    // Command codes understood by the executor
    localparam logic [7:0] CMD_ADD  = 8'h01; // res0 = arg0 + arg1, res1 = 0
    localparam logic [7:0] CMD_SWAP = 8'h02; // res0 = arg1, res1 = arg0
    localparam logic [7:0] CMD_IRQ  = 8'h03; // Results kept, raises irq

    // Status register bit positions
    localparam int STAT_PENDING_BIT = 15;
    localparam int STAT_ERROR_BIT   = 14;
    localparam int STAT_IRQ_BIT     = 13;

    // Four-word unlock sequence, written to either key slot
    localparam logic [DATA_W-1:0] UNLOCK_KEY [4] = '{
        16'h5F55,
        16'h4E4C,
        16'h4F43,
        16'h4B5F
    };

    // Two of these in a row relock the mailbox
    localparam logic [DATA_W-1:0] LOCK_WORD = 16'hFFFF;

    localparam logic [WORD_W-1:0] CFG_VERSION = 32'h0001_0200;

endpackage
